//--- lsu_core.f
source/lsu_pkg.sv
source/lsu_store_path.sv
source/lsu_load_align.sv
source/lsu_ctrl_fsm.sv
source/lsu_top.sv
tb/lsu_mem_model.sv
tb/tb_lsu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the LSU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lsu_top -f lsu_core.f -o sim_lsu

out=$(./obj_dir/sim_lsu)
echo "$out"

# the run passes only if the pass line shows up
echo "$out" | grep -q "^Simulation finished: PASS$"

//--- source/lsu_ctrl_fsm.sv
// req/gnt/rvalid handshake, at most one access waits for rvalid
// while a second one is being requested
// no new request leaves while the ex stage is stalled after a grant

`timescale 1ns/1ps

module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_i,        // ex stage wants an access
  input  lsu_mem_rsp_t mem_rsp_i,
  input  logic         we_i,
  input  logic         ex_valid_i,   // low while ex stage is stalled
  output logic         data_req_o,
  output logic         lsu_ready_ex_o,
  output logic         lsu_ready_wb_o,
  output logic         busy_o,
  output logic         load_err_o,
  output logic         store_err_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RVALID,
    WAIT_RVALID_EX_STALL,
    IDLE_EX_STALL
  } state_e;

  state_e state_q, state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = req_i;
        if (req_i)
        begin
          lsu_ready_ex_o = mem_rsp_i.gnt;   // hold ex stage until granted
          if (mem_rsp_i.gnt)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = mem_rsp_i.rvalid;   // wb waits for the response
        if (mem_rsp_i.rvalid)
        begin
          data_req_o = req_i;   // back-to-back access
          if (req_i)
          begin
            lsu_ready_ex_o = mem_rsp_i.gnt;
            if (mem_rsp_i.gnt)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;   // keep requesting from idle
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      WAIT_RVALID_EX_STALL:
      begin
        // stalled, no request out
        if (mem_rsp_i.rvalid)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;   // stall gone before the response
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;   // result already held
      end

      default: state_d = IDLE;
    endcase
  end

  assign busy_o = (state_q != IDLE) || data_req_o;

  // err arrives with gnt, split by direction
  assign load_err_o  = data_req_o && mem_rsp_i.gnt && mem_rsp_i.err && !we_i;
  assign store_err_o = data_req_o && mem_rsp_i.gnt && mem_rsp_i.err && we_i;

endmodule

//--- source/lsu_load_align.sv
// load alignment and extension, attributes are sampled on every grant
// the second part of a split load must be granted after the first part's rvalid
// rdata_o shows the live result only while rvalid is high

`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  lsu_attr_t           attr_i,
  input  logic                misaligned_i,   // split access pending or in progress
  input  lsu_mem_rsp_t        mem_rsp_i,
  output logic [LSU_XLEN-1:0] rdata_o
);

  lsu_attr_t           attr_q;      // attributes of the access waiting for rvalid
  logic [LSU_XLEN-1:0] rdata_q;     // raw first part or last finished result
  logic [LSU_XLEN-1:0] rdata_w;
  logic [LSU_XLEN-1:0] rdata_h;
  logic [LSU_XLEN-1:0] rdata_b;
  logic [LSU_XLEN-1:0] rdata_ext;   // live result
  logic [15:0]         half_sel;
  logic [7:0]          byte_sel;

  // attributes follow each grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      attr_q <= '0;
    else if (mem_rsp_i.gnt)
      attr_q <= attr_i;
  end

  ////////////////////
  // word assembly
  ////////////////////
  // low bytes of a split word come from the held first part
  always_comb
  begin
    case (attr_q.offset)
      2'b00:   rdata_w = mem_rsp_i.rdata;
      2'b01:   rdata_w = {mem_rsp_i.rdata[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {mem_rsp_i.rdata[15:0], rdata_q[31:16]};
      default: rdata_w = {mem_rsp_i.rdata[23:0], rdata_q[31:24]};
    endcase
  end

  ////////////////////
  // half and byte
  ////////////////////
  always_comb
  begin
    case (attr_q.offset)
      2'b00:   half_sel = mem_rsp_i.rdata[15:0];
      2'b01:   half_sel = mem_rsp_i.rdata[23:8];
      2'b10:   half_sel = mem_rsp_i.rdata[31:16];
      default: half_sel = {mem_rsp_i.rdata[7:0], rdata_q[31:24]};   // split halfword
    endcase
  end

  assign byte_sel = mem_rsp_i.rdata[{attr_q.offset, 3'b000} +: 8];

  // extension, zero unless sign_ext was set at grant
  assign rdata_h = {{16{attr_q.sign_ext & half_sel[15]}}, half_sel};
  assign rdata_b = {{24{attr_q.sign_ext & byte_sel[7]}}, byte_sel};

  always_comb
  begin
    case (attr_q.size)
      SIZE_WORD: rdata_ext = rdata_w;
      SIZE_HALF: rdata_ext = rdata_h;
      default:   rdata_ext = rdata_b;
    endcase
  end

  ////////////////////
  // held result
  ////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (mem_rsp_i.rvalid && !attr_q.we)
    begin
      // first part keeps the raw word for the assembly of the second
      if (misaligned_i)
        rdata_q <= mem_rsp_i.rdata;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_o = mem_rsp_i.rvalid ? rdata_ext : rdata_q;   // bypass in the rvalid cycle

endmodule

//--- source/lsu_pkg.sv
// shared types for the load/store unit
// data path is fixed at 32 bits over four byte lanes, little-endian
// size code 2'b11 is not named and the blocks treat it as a byte

package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int unsigned LSU_XLEN   = 32;            // data and address width
  localparam int unsigned LSU_NBYTES = LSU_XLEN / 8;  // byte lanes

  // access size as encoded by the decoder
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  ////////////////////
  // structs
  ////////////////////
  typedef struct packed {
    logic                  req;         // access request from ex stage
    logic                  we;          // 1 = store
    lsu_size_e             size;
    logic [LSU_XLEN-1:0]   wdata;       // store value, unrotated
    logic [1:0]            reg_offset;  // byte position of the value in its register
    logic                  sign_ext;    // sign-extend loaded halfwords and bytes
    logic [LSU_XLEN-1:0]   operand_a;   // base
    logic [LSU_XLEN-1:0]   operand_b;   // offset
    logic                  use_incr;    // address is a + b when set, a otherwise
    logic                  misaligned;  // second part of a split access
  } lsu_ex_req_t;

  // memory request payload, valid while data_req is high
  typedef struct packed {
    logic [LSU_XLEN-1:0]   addr;
    logic                  we;
    logic [LSU_NBYTES-1:0] be;
    logic [LSU_XLEN-1:0]   wdata;
  } lsu_mem_req_t;

  // memory response, err comes with gnt
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic                  err;
    logic [LSU_XLEN-1:0]   rdata;
  } lsu_mem_rsp_t;

  // attributes kept from grant until rvalid
  typedef struct packed {
    lsu_size_e             size;
    logic [1:0]            offset;      // address bits 1:0
    logic                  sign_ext;
    logic                  we;
  } lsu_attr_t;

endpackage

//--- source/lsu_store_path.sv
// combinational request path, payload follows ex_req_i in the same cycle
// a split access is flagged on the first part only, the second part is
// expected at address + 4 with the same low address bits

`timescale 1ns/1ps

module lsu_store_path import lsu_pkg::*; (
  input  lsu_ex_req_t  ex_req_i,
  output lsu_mem_req_t mem_req_o,
  output lsu_attr_t    attr_o,
  output logic         misaligned_o   // first part of a split access
);

  logic [LSU_XLEN-1:0]   addr;
  logic [1:0]            wdata_offset;   // lane rotation amount
  logic [LSU_NBYTES-1:0] be;
  logic [LSU_XLEN-1:0]   wdata_rot;

  // address adder
  assign addr = ex_req_i.use_incr ? (ex_req_i.operand_a + ex_req_i.operand_b)
                                  : ex_req_i.operand_a;

  ////////////////////
  // misalignment
  ////////////////////
  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_req_i.req && !ex_req_i.misaligned)
    begin
      case (ex_req_i.size)
        SIZE_WORD: misaligned_o = (addr[1:0] != 2'b00);   // any nonzero offset crosses
        SIZE_HALF: misaligned_o = (addr[1:0] == 2'b11);   // only the top lane crosses
        default:   misaligned_o = 1'b0;                   // bytes never cross
      endcase
    end
  end

  ////////////////////
  // byte enables
  ////////////////////
  always_comb
  begin
    case (ex_req_i.size)
      SIZE_WORD:
      begin
        if (!ex_req_i.misaligned)
          be = 4'b1111 << addr[1:0];                    // upper lanes from the offset
        else
          be = 4'b1111 >> (3'd4 - {1'b0, addr[1:0]});   // remaining low lanes
      end
      SIZE_HALF:
      begin
        if (!ex_req_i.misaligned)
          be = (addr[1:0] == 2'b11) ? 4'b1000 : (4'b0011 << addr[1:0]);
        else
          be = 4'b0001;   // spill byte of an offset-3 halfword
      end
      default: be = 4'b0001 << addr[1:0];   // byte, also the unnamed code
    endcase
  end

  ////////////////////
  // store data
  ////////////////////
  // register lane reg_offset has to land on memory lane addr[1:0]
  assign wdata_offset = addr[1:0] - ex_req_i.reg_offset;

  always_comb
  begin
    case (wdata_offset)
      2'b00:   wdata_rot = ex_req_i.wdata;
      2'b01:   wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  // memory payload
  assign mem_req_o.addr  = addr;
  assign mem_req_o.we    = ex_req_i.we;   // straight from ex stage
  assign mem_req_o.be    = be;
  assign mem_req_o.wdata = wdata_rot;

  // attributes for the load side, taken on grant
  assign attr_o.size     = ex_req_i.size;
  assign attr_o.offset   = addr[1:0];
  assign attr_o.sign_ext = ex_req_i.sign_ext;
  assign attr_o.we       = ex_req_i.we;

endmodule

//--- source/lsu_top.sv
// load/store unit between ex stage and a req/gnt/rvalid data port
// the controller must issue the second part of a split access itself
// mem_req_o is valid only while data_req_o is high

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // ex stage
  input  lsu_ex_req_t         ex_req_i,
  input  logic                ex_valid_i,
  output logic [LSU_XLEN-1:0] data_rdata_ex_o,
  output logic                data_misaligned_o,   // to controller, first part only
  output logic                load_err_o,
  output logic                store_err_o,
  output logic                lsu_ready_ex_o,
  output logic                lsu_ready_wb_o,
  output logic                busy_o,
  // data memory
  input  lsu_mem_rsp_t        mem_rsp_i,
  output logic                data_req_o,
  output lsu_mem_req_t        mem_req_o
);

  lsu_attr_t attr;
  logic      split_any;   // either part of a split access

  assign split_any = ex_req_i.misaligned || data_misaligned_o;

  lsu_store_path i_store_path (
    .ex_req_i     (ex_req_i),
    .mem_req_o    (mem_req_o),
    .attr_o       (attr),
    .misaligned_o (data_misaligned_o)
  );

  lsu_load_align i_load_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .attr_i       (attr),
    .misaligned_i (split_any),
    .mem_rsp_i    (mem_rsp_i),
    .rdata_o      (data_rdata_ex_o)
  );

  lsu_ctrl_fsm i_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (ex_req_i.req),
    .mem_rsp_i      (mem_rsp_i),
    .we_i           (ex_req_i.we),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o)
  );

endmodule

//--- tb/lsu_mem_model.sv
// behavioral data memory, 16 words at address bits 5:2, higher bits alias
// grant after 0 to 2 cycles, rvalid exactly one cycle after grant
// bit 31 set means error on grant and no write

`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         data_req_i,
  input  lsu_mem_req_t mem_req_i,
  output lsu_mem_rsp_t mem_rsp_o
);

  logic [31:0] mem [16];
  logic [1:0]  wait_cnt;       // cycles the current request has waited
  logic [1:0]  delay;          // grant delay of the current request
  logic        gnt;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  integer      seed = 13212;

  // fill that depends on the whole byte address of the word
  function automatic logic [31:0] init_word(input logic [5:0] a);
    init_word = {8'h80 ^ {2'b00, a}, 8'hf0 ^ {2'b00, a}, 8'h35 + {2'b00, a}, 8'hc2 ^ {2'b00, a}};
  endfunction

  assign gnt = data_req_i && (wait_cnt >= delay);

  assign mem_rsp_o.gnt    = gnt;
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.err    = gnt && mem_req_i.addr[31];   // error region
  assign mem_rsp_o.rdata  = rdata_q;

  always @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 16; i++)
        mem[i] <= init_word({i[3:0], 2'b00});
      wait_cnt <= '0;
      delay    <= '0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end
    else
    begin
      rvalid_q <= gnt;   // one response per grant
      if (gnt)
      begin
        rdata_q  <= mem[mem_req_i.addr[5:2]];
        wait_cnt <= '0;
        delay    <= 2'($unsigned($random(seed)) % 3);
        if (mem_req_i.we && !mem_req_i.addr[31])
          for (int b = 0; b < 4; b++)
            if (mem_req_i.be[b])
              mem[mem_req_i.addr[5:2]][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
      end
      else if (data_req_i)
      begin
        wait_cnt <= wait_cnt + 2'd1;   // still waiting
      end
    end
  end

endmodule

//--- tb/tb_lsu_top.sv
// directed tests for lsu_top, the testbench acts as ex stage and controller
// split accesses are finished by issuing the second part at address + 4
// expected values come from a byte-wide shadow of the memory model

`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

  logic         clk;
  logic         rst_n;
  lsu_ex_req_t  ex_req;
  logic         ex_valid;
  lsu_mem_rsp_t mem_rsp;
  lsu_mem_req_t mem_req;
  logic         data_req, mis_o, load_err, store_err;
  logic         ready_ex, ready_wb, busy;
  logic [31:0]  rdata_ex;
  logic [7:0]   shadow [64];   // byte image of the memory model
  int           err_count;
  int           tests_pass;
  int           tests_fail;

  lsu_top i_lsu_top (
    .clk (clk), .rst_n (rst_n),
    .ex_req_i (ex_req), .ex_valid_i (ex_valid),
    .data_rdata_ex_o (rdata_ex), .data_misaligned_o (mis_o),
    .load_err_o (load_err), .store_err_o (store_err),
    .lsu_ready_ex_o (ready_ex), .lsu_ready_wb_o (ready_wb), .busy_o (busy),
    .mem_rsp_i (mem_rsp), .data_req_o (data_req), .mem_req_o (mem_req)
  );

  lsu_mem_model i_mem (
    .clk (clk), .rst_n (rst_n), .data_req_i (data_req),
    .mem_req_i (mem_req), .mem_rsp_o (mem_rsp)
  );

  always #4 clk = ~clk;   // 8 ns period

  ////////////////////
  // helpers
  ////////////////////
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  // a bounded wait ran out
  task automatic note_timeout(input string why);
    $display("timeout: %s after 50 cycles", why);
    err_count++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before)
    begin
      tests_pass++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_fail++;
      $display("test %s: failed", name);
    end
  endtask

  // store of n bytes, memory byte a+k takes register byte (roff+k) mod 4
  task automatic store_shadow(input logic [31:0] a, input lsu_size_e sz,
                              input logic [31:0] wd, input logic [1:0] roff);
    int n;
    n = (sz == SIZE_WORD) ? 4 : (sz == SIZE_HALF) ? 2 : 1;
    for (int k = 0; k < n; k++)
      shadow[a[5:0] + 6'(k)] = wd[8*(2'(roff + 2'(k))) +: 8];
  endtask

  // little-endian bytes from a, then zero or sign extension
  function automatic logic [31:0] exp_load(input logic [31:0] a, input lsu_size_e sz,
                                           input logic sx);
    logic [31:0] v;
    int          n;
    v = '0;
    n = (sz == SIZE_WORD) ? 4 : (sz == SIZE_HALF) ? 2 : 1;
    for (int k = 0; k < n; k++)
      v[8*k +: 8] = shadow[a[5:0] + 6'(k)];
    if (sx && n == 2)
      v[31:16] = {16{v[15]}};
    if (sx && n == 1)
      v[31:8] = {24{v[7]}};
    return v;
  endfunction

  // one memory access, from request to rvalid
  task automatic run_access(input logic we, input lsu_size_e sz, input logic [31:0] a,
                            input logic [31:0] wd, input logic [1:0] roff, input logic sx,
                            input logic second, output logic [31:0] rd, output logic mis,
                            output logic lerr, output logic serr);
    lsu_ex_req_t r;
    int          n;
    logic        done;
    r = '0;
    r.req = 1'b1;
    r.we = we;
    r.size = sz;
    r.wdata = wd;
    r.reg_offset = roff;
    r.sign_ext = sx;
    r.operand_a = {a[31:2], 2'b00};   // base plus low bits through the adder
    r.operand_b = {30'd0, a[1:0]};
    r.use_incr = 1'b1;
    r.misaligned = second;
    {mis, lerr, serr} = '0;
    rd = '0;
    @(posedge clk);
    ex_req <= r;
    n = 0;
    done = 1'b0;
    while (!done && n < 50)
    begin
      @(negedge clk);
      if (data_req && mem_rsp.gnt)
      begin
        done = 1'b1;
        mis  = mis_o;
        lerr = load_err;
        serr = store_err;
        check_eq(32'(ready_ex), 1, "ready_ex in grant cycle");
      end
      else
      begin
        check_eq(32'(ready_ex), 0, "ready_ex while waiting for grant");
      end
      n++;
    end
    if (!done)
      note_timeout("no grant");
    else
    begin
      @(posedge clk);
      r.req = 1'b0;
      r.misaligned = mis;   // first part of a split keeps the raw word
      ex_req <= r;
      n = 0;
      done = 1'b0;
      while (!done && n < 50)
      begin
        @(negedge clk);
        if (mem_rsp.rvalid)
        begin
          done = 1'b1;
          rd = rdata_ex;
          check_eq(32'(ready_wb), 1, "ready_wb in rvalid cycle");
        end
        n++;
      end
      if (!done)
        note_timeout("no rvalid");
    end
  endtask

  // whole access, adds the second part when the first one is split
  task automatic access(input logic we, input lsu_size_e sz, input logic [31:0] a,
                        input logic [31:0] wd, input logic [1:0] roff, input logic sx,
                        output logic [31:0] rd, output logic mis,
                        output logic lerr, output logic serr);
    logic m2, l2, s2;
    run_access(we, sz, a, wd, roff, sx, 1'b0, rd, mis, lerr, serr);
    if (mis)
      run_access(we, sz, a + 32'd4, wd, roff, sx, 1'b1, rd, m2, l2, s2);
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic test_reset();
    int e;
    e = err_count;
    check_eq(32'(data_req), 0, "data_req after reset");
    check_eq(32'(busy), 0, "busy after reset");
    check_eq(32'(ready_ex), 1, "ready_ex after reset");
    check_eq(32'(ready_wb), 1, "ready_wb after reset");
    check_eq(rdata_ex, 0, "held data after reset");
    report_test("reset", e);
  endtask

  task automatic test_aligned();
    int          e;
    logic [31:0] rd;
    logic        m, le, se;
    e = err_count;
    access(1, SIZE_WORD, 32'h00, 32'h1122_3344, 2'd0, 0, rd, m, le, se);
    store_shadow(32'h00, SIZE_WORD, 32'h1122_3344, 2'd0);
    for (int o = 0; o < 3; o++)
    begin
      access(1, SIZE_HALF, 32'h04 + o, 32'hcafe_5a00 + o, 2'(o + 1), 0, rd, m, le, se);
      store_shadow(32'h04 + o, SIZE_HALF, 32'hcafe_5a00 + o, 2'(o + 1));
    end
    for (int o = 0; o < 4; o++)
    begin
      access(1, SIZE_BYTE, 32'h08 + o, 32'h9876_5400 + o, 2'(o % 3 + 1), 0, rd, m, le, se);
      store_shadow(32'h08 + o, SIZE_BYTE, 32'h9876_5400 + o, 2'(o % 3 + 1));
    end
    for (int w = 0; w < 3; w++)
    begin
      access(0, SIZE_WORD, 32'(4 * w), 0, 2'd0, 0, rd, m, le, se);
      check_eq(rd, exp_load(32'(4 * w), SIZE_WORD, 0), $sformatf("readback word %0d", w));
    end
    report_test("aligned", e);
  endtask

  task automatic test_extension();
    int          e;
    logic [31:0] rd;
    logic        m, le, se;
    e = err_count;
    // sign bit set in every halfword, in every byte but lane 0 of the first word
    access(1, SIZE_WORD, 32'h14, 32'hf1e2_d34c, 2'd0, 0, rd, m, le, se);
    store_shadow(32'h14, SIZE_WORD, 32'hf1e2_d34c, 2'd0);
    access(1, SIZE_WORD, 32'h18, 32'h8a9b_acbd, 2'd0, 0, rd, m, le, se);
    store_shadow(32'h18, SIZE_WORD, 32'h8a9b_acbd, 2'd0);
    for (int sx = 0; sx < 2; sx++)
    begin
      for (int o = 0; o < 3; o++)
      begin
        access(0, SIZE_HALF, 32'h14 + o, 0, 2'd0, sx[0], rd, m, le, se);
        check_eq(rd, exp_load(32'h14 + o, SIZE_HALF, sx[0]), $sformatf("half off %0d", o));
      end
      for (int o = 0; o < 4; o++)
      begin
        access(0, SIZE_BYTE, 32'h18 + o, 0, 2'd0, sx[0], rd, m, le, se);
        check_eq(rd, exp_load(32'h18 + o, SIZE_BYTE, sx[0]), $sformatf("byte off %0d", o));
      end
    end
    report_test("extension", e);
  endtask

  task automatic test_misaligned();
    int          e;
    logic [31:0] rd;
    logic        m, le, se;
    e = err_count;
    for (int o = 1; o < 4; o++)
    begin
      access(0, SIZE_WORD, 32'h20 + o, 0, 2'd0, 0, rd, m, le, se);
      check_eq(32'(m), 1, $sformatf("split flag word off %0d", o));
      check_eq(rd, exp_load(32'h20 + o, SIZE_WORD, 0), $sformatf("split word off %0d", o));
    end
    access(0, SIZE_HALF, 32'h2b, 0, 2'd0, 1, rd, m, le, se);
    check_eq(32'(m), 1, "split flag half");
    check_eq(rd, exp_load(32'h2b, SIZE_HALF, 1), "split half");
    access(1, SIZE_WORD, 32'h32, 32'hdead_beef, 2'd1, 0, rd, m, le, se);
    check_eq(32'(m), 1, "split flag store");
    store_shadow(32'h32, SIZE_WORD, 32'hdead_beef, 2'd1);
    access(0, SIZE_WORD, 32'h30, 0, 2'd0, 0, rd, m, le, se);
    check_eq(rd, exp_load(32'h30, SIZE_WORD, 0), "split store low word");
    access(0, SIZE_WORD, 32'h34, 0, 2'd0, 0, rd, m, le, se);
    check_eq(rd, exp_load(32'h34, SIZE_WORD, 0), "split store high word");
    report_test("misaligned", e);
  endtask

  task automatic test_errors();
    int          e;
    logic [31:0] rd;
    logic        m, le, se;
    e = err_count;
    access(0, SIZE_WORD, 32'h8000_0010, 0, 2'd0, 0, rd, m, le, se);
    check_eq(32'({le, se}), 32'h2, "load error flags");
    access(1, SIZE_WORD, 32'h8000_0010, 32'h0bad_f00d, 2'd0, 0, rd, m, le, se);
    check_eq(32'({le, se}), 32'h1, "store error flags");
    access(0, SIZE_WORD, 32'h10, 0, 2'd0, 0, rd, m, le, se);
    check_eq(rd, exp_load(32'h10, SIZE_WORD, 0), "memory after failed store");
    report_test("errors", e);
  endtask

  task automatic test_stall();
    int          e;
    int          n;
    logic [31:0] rd;
    logic [31:0] exp;
    logic        m, le, se;
    e = err_count;
    exp = exp_load(32'h1c, SIZE_WORD, 0);
    @(posedge clk);
    ex_valid <= 1'b0;
    access(0, SIZE_WORD, 32'h1c, 0, 2'd0, 0, rd, m, le, se);
    check_eq(rd, exp, "stalled load");
    @(posedge clk);
    ex_req.req <= 1'b1;   // pending request must stay inside the LSU
    for (int c = 0; c < 5; c++)
    begin
      @(negedge clk);
      check_eq(32'(busy), 1, "busy while stalled");
      check_eq(32'(data_req), 0, "request while stalled");
      check_eq(rdata_ex, exp, "held data while stalled");
    end
    @(posedge clk);
    ex_req.req <= 1'b0;
    ex_valid   <= 1'b1;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (busy && n < 50);
    if (busy)
      note_timeout("busy stuck high after stall");
    check_eq(rdata_ex, exp, "held data after stall");
    report_test("stall", e);
  endtask

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b0;
    ex_req = '0;
    ex_valid = 1'b1;
    err_count = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // memory image as loaded during reset
    for (int i = 0; i < 64; i++)
      shadow[i] = i_mem.mem[i[5:2]][8*(i % 4) +: 8];
    @(negedge clk);
    test_reset();
    test_aligned();
    test_extension();
    test_misaligned();
    test_errors();
    test_stall();
    $display("tests passed %0d failed %0d, errors %0d", tests_pass, tests_fail, err_count);
    if (tests_fail == 0 && err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
